// ==== files.f ====
+incdir+hdl
hdl/dzcpuPkg.sv
hdl/memAccessIf.sv
hdl/aluUnit.sv
hdl/busMaster.sv
hdl/datapath.sv
hdl/microSequencer.sv
hdl/dzcpuTop.sv
testbench/tbDzcpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tbDzcpu -o tbDzcpu \
  && ./obj_dir/tbDzcpu > sim.log 2>&1 \
  || { echo "Build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

// ==== testbench/tbDzcpu.sv ====
`timescale 1ns/1ps

module tbDzcpu;
  logic        iClock = 1'b0;
  logic        rst = 1'b1;
  logic        memReq;
  logic        memAck = 1'b0;
  logic        memWe;
  logic [15:0] memAddr;
  logic [7:0]  memWData;
  logic [7:0]  memRData = 8'h00;
  logic        flowEnd;

  logic [7:0]  memory [256];
  logic [7:0]  image [256];
  logic [24:0] expAcc [$];        // {we, data, addr}
  logic [31:0] rngState = 32'h34df5ec6;
  logic [31:0] ackState = 32'h34df5ec6;
  int          progLen;
  int          flowCount;
  int          accCount;
  int          errors = 0;
  int          testsRun = 0;
  int          testsFailed = 0;
  int          ackDelay;
  bit          running = 1'b0;
  bit          timedOut = 1'b0;
  bit          prevReq = 1'b0;
  bit          ackPending = 1'b0;
  string       testNames [6] = '{"reset and fetch", "loads", "alu", "jumps", "hl reads",
                                 "random program"};

  dzcpuTop dut0 (
    .iClock(iClock), .rst(rst),
    .memReq(memReq), .memAck(memAck), .memWe(memWe),
    .memAddr(memAddr), .memWData(memWData), .memRData(memRData),
    .flowEnd(flowEnd)
  );

  initial
  begin
    forever #4 iClock = ~iClock;
  end

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [7:0] randomByte();
    rngState = xorshift(rngState);
    return rngState[7:0];
  endfunction

  function automatic logic [2:0] randomReg();
    logic [2:0] r;
    r = 3'(randomByte() % 5);
    return (r == 3'd4) ? 3'd7 : r;    // B C D E A
  endfunction

  // Returns {flags, result}
  function automatic logic [15:0] aluRef(logic [3:0] op, logic [7:0] a, logic [7:0] b,
                                         logic [7:0] f);
    logic [7:0] res;
    logic       n;
    logic       h;
    logic       c;
    n = 1'b0;
    h = 1'b0;
    c = f[4];
    case (op)
      4'd0:
      begin
        res = a + b;
        h = (int'(a[3:0]) + int'(b[3:0])) > 15;
        c = (int'(a) + int'(b)) > 255;
      end
      4'd2, 4'd7:
      begin
        res = a - b;
        n = 1'b1;
        h = a[3:0] < b[3:0];
        c = a < b;
      end
      4'd4:
      begin
        res = a & b;
        h = 1'b1;
        c = 1'b0;
      end
      4'd5:
      begin
        res = a ^ b;
        c = 1'b0;
      end
      4'd6:
      begin
        res = a | b;
        c = 1'b0;
      end
      4'd8:
      begin
        res = a + 8'd1;
        h = (res[3:0] == 4'h0);
      end
      default:
      begin
        res = a - 8'd1;
        n = 1'b1;
        h = (res[3:0] == 4'hF);
      end
    endcase
    return {res == 8'h00, n, h, c, 4'h0, res};
  endfunction

  // ISA model that runs from address 0 to endPc and fills expAcc
  function automatic int predict(int endPc);
    logic [7:0]  mem [256];
    logic [7:0]  r [8];
    logic [7:0]  f;
    logic [15:0] pc;
    logic [15:0] hl;
    logic [15:0] aluOut;
    logic [7:0]  op;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic        take;
    int          count;
    mem = image;
    foreach (r[i])
      r[i] = 8'h00;
    f = 8'hB0;
    pc = 16'h0000;
    count = 0;
    expAcc.delete();
    while (int'(pc) != endPc && count < 400)
    begin
      expAcc.push_back({1'b0, 8'h00, pc});
      op = mem[pc[7:0]];
      pc = pc + 16'd1;
      count++;
      hl = {r[4], r[5]};
      if (op[7:6] == 2'd0 && op[5:3] != 3'd6 && op[2:0] == 3'd6)
      begin
        expAcc.push_back({1'b0, 8'h00, pc});  // LD r,n
        r[op[5:3]] = mem[pc[7:0]];
        pc = pc + 16'd1;
      end
      else if (op[7:6] == 2'd0 && op[5:3] != 3'd6 && op[2:1] == 2'b10)
      begin
        aluOut = aluRef(op[0] ? 4'd9 : 4'd8, r[op[5:3]], 8'h00, f);
        r[op[5:3]] = aluOut[7:0];
        f = aluOut[15:8];
      end
      else if (op == 8'h77)
      begin
        expAcc.push_back({1'b1, r[7], hl});
        mem[hl[7:0]] = r[7];
      end
      else if (op == 8'h7E)
      begin
        expAcc.push_back({1'b0, 8'h00, hl});
        r[7] = mem[hl[7:0]];
      end
      else if (op[7:6] == 2'd1 && op[5:3] != 3'd6 && op[2:0] != 3'd6)
        r[op[5:3]] = r[op[2:0]];
      else if (op[7:6] == 2'd2 && op[2:0] != 3'd6 && op[5:3] != 3'd1 && op[5:3] != 3'd3)
      begin
        aluOut = aluRef({1'b0, op[5:3]}, r[7], r[op[2:0]], f);
        if (op[5:3] != 3'd7)
          r[7] = aluOut[7:0];
        f = aluOut[15:8];
      end
      else if (op == 8'hC3 || op == 8'hC2 || op == 8'hCA || op == 8'hD2 || op == 8'hDA)
      begin
        expAcc.push_back({1'b0, 8'h00, pc});
        lo = mem[pc[7:0]];
        pc = pc + 16'd1;
        expAcc.push_back({1'b0, 8'h00, pc});
        hi = mem[pc[7:0]];
        pc = pc + 16'd1;
        case (op)
          8'hC2:   take = !f[7];
          8'hCA:   take = f[7];
          8'hD2:   take = !f[4];
          8'hDA:   take = f[4];
          default: take = 1'b1;
        endcase
        if (take)
          pc = {hi, lo};
      end
    end
    return count;
  endfunction

  task automatic reportValue(string name, int got, int want);
    $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, want);
    errors++;
  endtask

  task automatic checkAccess();
    logic [24:0] exp;
    accCount++;
    if (expAcc.size() == 0)
    begin
      $display("Bus access at %0h was not predicted by the model", memAddr);
      errors++;
    end
    else
    begin
      exp = expAcc.pop_front();
      if (memAddr !== exp[15:0])
        reportValue("memAddr", memAddr, exp[15:0]);
      if (memWe !== exp[24])
        reportValue("memWe", memWe, exp[24]);
      if (exp[24] && memWData !== exp[23:16])
        reportValue("memWData", memWData, exp[23:16]);
    end
  endtask

  // Memory model answering the four-phase handshake after a random delay
  always @(negedge iClock)
  begin
    if (memAck)
    begin
      if (!memReq)
        memAck = 1'b0;
    end
    else if (memReq)
    begin
      if (!ackPending)
      begin
        ackState = xorshift(ackState);
        ackDelay = int'(ackState[1:0]);
        ackPending = 1'b1;
      end
      if (ackDelay == 0)
      begin
        if (memWe)
          memory[memAddr[7:0]] = memWData;
        else
          memRData = memory[memAddr[7:0]];
        memAck = 1'b1;
        ackPending = 1'b0;
      end
      else
        ackDelay--;
    end
  end

  // Compares each new request and counts flowEnd
  always @(posedge iClock)
  begin
    if (!running)
      prevReq = 1'b0;
    else
    begin
      if (flowEnd)
      begin
        if (accCount == 0)
        begin
          $display("flowEnd pulsed before the first bus access at t=%0t", $time);
          errors++;
        end
        flowCount++;
      end
      if (memReq && !prevReq)
        checkAccess();
      prevReq = memReq;
    end
  end

  task automatic newProgram();
    foreach (image[i])
      image[i] = 8'(i * 37 + 11);     // Filler from the address
    progLen = 0;
  endtask

  task automatic emit(logic [7:0] b);
    image[progLen] = b;
    progLen++;
  endtask

  task automatic emitLdN(logic [2:0] r, logic [7:0] n);
    emit({2'b00, r, 3'b110});
    emit(n);
  endtask

  task automatic storeA(logic [7:0] addr);
    emitLdN(3'd5, addr);
    emit(8'h77);
  endtask

  function automatic logic [7:0] jumpOpcode(logic [7:0] rnd);
    if (rnd[2:0] >= 3'd5)
      return 8'hC3;
    return {3'b110, rnd[1:0], 3'b010};  // NZ Z NC C
  endfunction

  task automatic buildBasics();
    newProgram();
    emit(8'h00);
    emitLdN(3'd7, 8'h3C);
    emit(8'h76);                        // HALT runs as NOP
    emit(8'h88);                        // ADC runs as NOP
    storeA(8'h80);
  endtask

  task automatic buildLoads();
    logic [2:0] d;
    logic [2:0] s;
    newProgram();
    emitLdN(3'd0, randomByte());
    emitLdN(3'd1, randomByte());
    emitLdN(3'd2, randomByte());
    emitLdN(3'd3, randomByte());
    emitLdN(3'd7, randomByte());
    for (int i = 0; i < 8; i++)
    begin
      d = randomReg();
      s = randomReg();
      emit({2'b01, d, s});
      emit({2'b01, 3'd7, d});
      storeA(8'(8'h90 + i));
    end
  endtask

  task automatic buildAlu();
    logic [2:0] ops [5];
    logic [2:0] r;
    ops = '{3'd0, 3'd2, 3'd4, 3'd5, 3'd6};
    newProgram();
    for (int i = 0; i < 8; i++)
    begin
      r = randomReg();
      emitLdN(r, randomByte());
      emitLdN(3'd7, randomByte());
      emit({2'b10, ops[randomByte() % 5], r});
      storeA(8'(8'hA0 + i));
      r = randomReg();
      emitLdN(r, randomByte());
      emit({2'b00, r, 2'b10, i[0]});    // INC or DEC
      emit({2'b01, 3'd7, r});
      storeA(8'(8'hB0 + i));
    end
  endtask

  task automatic buildJumps();
    logic [2:0] ops [5];
    logic [7:0] a;
    logic [7:0] b;
    int         tgt;
    ops = '{3'd0, 3'd2, 3'd4, 3'd5, 3'd6};
    newProgram();
    for (int i = 0; i < 10; i++)
    begin
      a = randomByte();
      b = randomByte();
      emitLdN(3'd0, b[0] ? a : randomByte());  // Equal operands half the time
      emitLdN(3'd7, a);
      emit({2'b10, b[1] ? 3'd7 : ops[b[4:2] % 5], 3'd0});
      tgt = progLen + 6;
      emit(jumpOpcode(randomByte()));
      emit(tgt[7:0]);
      emit(8'h00);
      storeA(8'(8'hC8 + i));
    end
  endtask

  task automatic buildHlReads();
    newProgram();
    for (int i = 0; i < 8; i++)
    begin
      image[8'hD0 + i] = randomByte();
      emitLdN(3'd5, 8'(8'hD0 + i));
      emit(8'h7E);
      storeA(8'(8'hE0 + i));
    end
  endtask

  task automatic buildRandom();
    logic [2:0] s;
    int         tgt;
    newProgram();
    emitLdN(3'd5, 8'hE0);
    while (progLen < 8'h60)
    begin
      s = 3'(randomByte() % 8);
      if (s == 3'd6)
        s = 3'd7;                       // Any register but (HL)
      case (randomByte() % 8)
        0: emitLdN(randomReg(), randomByte());
        1: emit({2'b01, randomReg(), s});
        2: emit({2'b10, 3'(randomByte() % 8), s});
        3: emit({2'b00, randomReg(), 2'b10, 1'(randomByte() % 2)});
        4: emit(8'h77);
        5: emit(8'h7E);
        6:
        begin
          tgt = progLen + 4;
          emit(jumpOpcode(randomByte()));
          emit(tgt[7:0]);
          emit(8'h00);
          emit(8'h04);                  // INC B skipped when taken
        end
        default: emit(randomByte() % 2 ? 8'h00 : 8'h76);
      endcase
    end
  endtask

  task automatic runTest(string name);
    int nInsn;
    int limit;
    int cycles;
    int errBefore;
    errBefore = errors;
    nInsn = predict(progLen);
    limit = 40 * nInsn;
    @(negedge iClock);
    rst = 1'b1;
    running = 1'b0;
    repeat (10)
    begin
      @(negedge iClock);
      if (memReq !== 1'b0)
        reportValue("memReq", memReq, 0);
      if (flowEnd !== 1'b0)
        reportValue("flowEnd", flowEnd, 0);
    end
    memory = image;
    flowCount = 0;
    accCount = 0;
    running = 1'b1;
    rst = 1'b0;
    cycles = 0;
    while (flowCount < nInsn && cycles < limit)
    begin
      @(negedge iClock);
      cycles++;
    end
    running = 1'b0;
    testsRun++;
    if (flowCount < nInsn)
    begin
      $display("Timeout in test %s, %0d of %0d instructions ended", name, flowCount, nInsn);
      timedOut = 1'b1;
      errors++;
    end
    else if (expAcc.size() != 0)
    begin
      $display("Test %s ended with %0d predicted accesses missing", name, expAcc.size());
      errors++;
    end
    if (errors == errBefore)
      $display("test %s: ok, %0d instructions", name, nInsn);
    else
    begin
      testsFailed++;
      $display("test %s: %0d errors", name, errors - errBefore);
    end
  endtask

  initial
  begin
    for (int t = 0; t < 6 && !timedOut; t++)
    begin
      case (t)
        0: buildBasics();
        1: buildLoads();
        2: buildAlu();
        3: buildJumps();
        4: buildHlReads();
        default: buildRandom();
      endcase
      runTest(testNames[t]);
    end
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0 && !timedOut)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end
endmodule

// ==== hdl/dzcpuTop.sv ====
`timescale 1ns/1ps
`include "dzcpu_defines.svh"

module dzcpuTop
(
  input  logic                  iClock,
  input  logic                  rst,
  output logic                  memReq,
  input  logic                  memAck,
  output logic                  memWe,
  output logic [`DZ_ADDR_W-1:0] memAddr,
  output logic [`DZ_DATA_W-1:0] memWData,
  input  logic [`DZ_DATA_W-1:0] memRData,
  output logic                  flowEnd
);
  memAccessIf memBus ();

  dzcpuPkg::uopT         uop;
  dzcpuPkg::zInsnT       insn;
  logic                  fire;
  logic [`DZ_DATA_W-1:0] flags;

  microSequencer seq0 (
    .iClock(iClock), .rst(rst),
    .mem(memBus.control),
    .flags(flags),
    .uop(uop), .insn(insn),
    .fire(fire), .flowEnd(flowEnd)
  );

  datapath dp0 (
    .iClock(iClock), .rst(rst),
    .mem(memBus.data),
    .uop(uop), .insn(insn),
    .fire(fire), .flags(flags)
  );

  busMaster bus0 (
    .iClock(iClock), .rst(rst),
    .mem(memBus.master),
    .memReq(memReq), .memWe(memWe),
    .memAddr(memAddr), .memWData(memWData),
    .memAck(memAck), .memRData(memRData)
  );
endmodule

// ==== hdl/microSequencer.sv ====
`timescale 1ns/1ps
`include "dzcpu_defines.svh"

module microSequencer
(
  input  logic                  iClock,
  input  logic                  rst,
  memAccessIf.control           mem,
  input  logic [`DZ_DATA_W-1:0] flags,
  output dzcpuPkg::uopT         uop,
  output dzcpuPkg::zInsnT       insn,
  output logic                  fire,
  output logic                  flowEnd
);
  // Flow entry points in the microcode store
  localparam logic [`DZ_UPC_W-1:0] upcFetch  = 4'd0;
  localparam logic [`DZ_UPC_W-1:0] upcNop    = 4'd1;
  localparam logic [`DZ_UPC_W-1:0] upcLdN    = 4'd2;
  localparam logic [`DZ_UPC_W-1:0] upcLdRR   = 4'd3;
  localparam logic [`DZ_UPC_W-1:0] upcLdAHl  = 4'd4;
  localparam logic [`DZ_UPC_W-1:0] upcLdHlA  = 4'd5;
  localparam logic [`DZ_UPC_W-1:0] upcAlu    = 4'd6;
  localparam logic [`DZ_UPC_W-1:0] upcJpLo   = 4'd7;
  localparam logic [`DZ_UPC_W-1:0] upcJpHi   = 4'd8;
  localparam logic [`DZ_UPC_W-1:0] upcJpGo   = 4'd9;

  typedef enum logic [1:0] {seqReset, seqIssue, seqBusy} seqStateT;

  seqStateT              state;
  logic [`DZ_UPC_W-1:0]  upc;
  dzcpuPkg::zInsnT       insnReg;
  dzcpuPkg::uopT         uRom [`DZ_UROM_DEPTH];
  logic                  condTrue;
  logic                  eofHit;

  function automatic logic [`DZ_UPC_W-1:0] flowLookup(dzcpuPkg::zInsnT op);
    logic [`DZ_UPC_W-1:0] idx;
    idx = upcNop;                       // Anything unknown runs as NOP
    case (op.ld.group)
      2'd0:
        if (op.ld.dst != 3'd6)
          case (op.ld.src)
            3'b110:         idx = upcLdN;
            3'b100, 3'b101: idx = upcAlu;  // INC/DEC
            default:        idx = upcNop;
          endcase
      2'd1:
        if (op.ld.dst == 3'd6 && op.ld.src == 3'd7)
          idx = upcLdHlA;
        else if (op.ld.dst == 3'd7 && op.ld.src == 3'd6)
          idx = upcLdAHl;
        else if (op.ld.dst != 3'd6 && op.ld.src != 3'd6)
          idx = upcLdRR;
      2'd2:
        if (op.opr.src != 3'd6 && op.opr.op != 3'd1 && op.opr.op != 3'd3)
          idx = upcAlu;                 // No ADC/SBC
      default:
        if (op == 8'hC3 || (!op.opr.op[2] && op.opr.src == 3'b010))
          idx = upcJpLo;
    endcase
    return idx;
  endfunction

  always_comb
  begin
    uRom[upcFetch] = '{dzcpuPkg::cmdFetch, dzcpuPkg::memRead, dzcpuPkg::addrPc, 1'b1,
                       dzcpuPkg::eofNever};
    uRom[upcNop]   = '{dzcpuPkg::cmdNone, dzcpuPkg::memNone, dzcpuPkg::addrPc, 1'b0,
                       dzcpuPkg::eofAlways};
    uRom[upcLdN]   = '{dzcpuPkg::cmdRegFromBus, dzcpuPkg::memRead, dzcpuPkg::addrPc, 1'b1,
                       dzcpuPkg::eofAlways};
    uRom[upcLdRR]  = '{dzcpuPkg::cmdRegFromReg, dzcpuPkg::memNone, dzcpuPkg::addrPc, 1'b0,
                       dzcpuPkg::eofAlways};
    uRom[upcLdAHl] = '{dzcpuPkg::cmdRegFromBus, dzcpuPkg::memRead, dzcpuPkg::addrHl, 1'b0,
                       dzcpuPkg::eofAlways};
    uRom[upcLdHlA] = '{dzcpuPkg::cmdNone, dzcpuPkg::memWrite, dzcpuPkg::addrHl, 1'b0,
                       dzcpuPkg::eofAlways};
    uRom[upcAlu]   = '{dzcpuPkg::cmdAlu, dzcpuPkg::memNone, dzcpuPkg::addrPc, 1'b0,
                       dzcpuPkg::eofAlways};
    uRom[upcJpLo]  = '{dzcpuPkg::cmdTempLo, dzcpuPkg::memRead, dzcpuPkg::addrPc, 1'b1,
                       dzcpuPkg::eofNever};
    uRom[upcJpHi]  = '{dzcpuPkg::cmdTempHi, dzcpuPkg::memRead, dzcpuPkg::addrPc, 1'b1,
                       dzcpuPkg::eofIfCondFalse};
    uRom[upcJpGo]  = '{dzcpuPkg::cmdJump, dzcpuPkg::memNone, dzcpuPkg::addrPc, 1'b0,
                       dzcpuPkg::eofAlways};
  end

  assign uop  = uRom[upc];
  assign insn = insnReg;

  always_comb
  begin
    case (insnReg.opr.op[1:0])
      2'd0:    condTrue = ~flags[`DZ_FLAG_Z];  // NZ
      2'd1:    condTrue = flags[`DZ_FLAG_Z];
      2'd2:    condTrue = ~flags[`DZ_FLAG_C];  // NC
      default: condTrue = flags[`DZ_FLAG_C];
    endcase
    if (insnReg.opr.src[0])
      condTrue = 1'b1;                      // JP nn
  end

  always_comb
  begin
    case (uop.eof)
      dzcpuPkg::eofAlways:      eofHit = 1'b1;
      dzcpuPkg::eofIfCondFalse: eofHit = ~condTrue;
      default:                  eofHit = 1'b0;
    endcase
  end

  assign mem.start = (state == seqIssue) && (uop.memOp != dzcpuPkg::memNone);
  assign mem.write = (uop.memOp == dzcpuPkg::memWrite);
  assign fire      = (state == seqBusy) && ((uop.memOp == dzcpuPkg::memNone) || mem.done);
  assign flowEnd   = fire && eofHit;

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      state   <= seqReset;
      upc     <= upcFetch;
      insnReg <= '0;
    end
    else
    begin
      case (state)
        seqReset: state <= seqIssue;
        seqIssue: state <= seqBusy;
        seqBusy:
          if (fire)
          begin
            state <= seqIssue;
            if (eofHit)
              upc <= upcFetch;
            else if (upc == upcFetch)
            begin
              upc     <= flowLookup(dzcpuPkg::zInsnT'(mem.rData));
              insnReg <= dzcpuPkg::zInsnT'(mem.rData);  // Opcode latch
            end
            else
              upc <= upc + 1'b1;
          end
        default: state <= seqReset;
      endcase
    end
  end
endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps
`include "dzcpu_defines.svh"

module datapath
(
  input  logic                  iClock,
  input  logic                  rst,
  memAccessIf.data              mem,
  input  dzcpuPkg::uopT         uop,
  input  dzcpuPkg::zInsnT       insn,
  input  logic                  fire,
  output logic [`DZ_DATA_W-1:0] flags
);
  logic [`DZ_DATA_W-1:0] regFile [8];   // B C D E H L - A
  logic [`DZ_ADDR_W-1:0] pc;
  logic [`DZ_ADDR_W-1:0] jumpTemp;
  dzcpuPkg::aluOpT       aluOp;
  logic                  incDec;
  logic [2:0]            aluDst;
  logic [`DZ_DATA_W-1:0] aluA;
  logic [`DZ_DATA_W-1:0] aluResult;
  logic [`DZ_DATA_W-1:0] aluFlags;

  assign mem.addr  = (uop.addrSel == dzcpuPkg::addrHl) ? {regFile[4], regFile[5]} : pc;
  assign mem.wData = regFile[insn.ld.src];

  // Opcode to ALU operation
  always_comb
  begin
    aluOp  = dzcpuPkg::aluAdd;
    incDec = 1'b0;
    if (insn.ld.group == 2'd0)
    begin
      incDec = 1'b1;
      aluOp  = insn.ld.src[0] ? dzcpuPkg::aluDec : dzcpuPkg::aluInc;
    end
    else
    begin
      case (insn.opr.op)
        3'd2:    aluOp = dzcpuPkg::aluSub;
        3'd4:    aluOp = dzcpuPkg::aluAnd;
        3'd5:    aluOp = dzcpuPkg::aluXor;
        3'd6:    aluOp = dzcpuPkg::aluOr;
        3'd7:    aluOp = dzcpuPkg::aluCp;
        default: aluOp = dzcpuPkg::aluAdd;
      endcase
    end
  end

  assign aluDst = incDec ? insn.ld.dst : 3'd7;
  assign aluA   = regFile[aluDst];

  aluUnit alu0 (
    .op(aluOp),
    .a(aluA),
    .b(regFile[insn.opr.src]),
    .flagsIn(flags),
    .result(aluResult),
    .flagsOut(aluFlags)
  );

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
        regFile[i] <= '0;
      pc    <= `DZ_RESET_PC;
      flags <= `DZ_FLAGS_INIT;
    end
    else if (fire)
    begin
      if (uop.cmd == dzcpuPkg::cmdJump)
        pc <= jumpTemp;
      else if (uop.incPc)
        pc <= pc + 1'b1;
      case (uop.cmd)
        dzcpuPkg::cmdRegFromBus: regFile[insn.ld.dst] <= mem.rData;
        dzcpuPkg::cmdRegFromReg: regFile[insn.ld.dst] <= regFile[insn.ld.src];
        dzcpuPkg::cmdAlu:
        begin
          flags <= aluFlags;
          if (aluOp != dzcpuPkg::aluCp)
            regFile[aluDst] <= aluResult;  // CP only compares
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (fire && uop.cmd == dzcpuPkg::cmdTempLo)
      jumpTemp[7:0] <= mem.rData;
    if (fire && uop.cmd == dzcpuPkg::cmdTempHi)
      jumpTemp[15:8] <= mem.rData;
  end
endmodule

// ==== hdl/busMaster.sv ====
`timescale 1ns/1ps
`include "dzcpu_defines.svh"

module busMaster
(
  input  logic                  iClock,
  input  logic                  rst,
  memAccessIf.master            mem,
  output logic                  memReq,
  output logic                  memWe,
  output logic [`DZ_ADDR_W-1:0] memAddr,
  output logic [`DZ_DATA_W-1:0] memWData,
  input  logic                  memAck,
  input  logic [`DZ_DATA_W-1:0] memRData
);
  typedef enum logic [1:0] {busIdle, busReq, busRelease} busStateT;

  busStateT              state;
  logic [`DZ_DATA_W-1:0] readData;

  assign mem.rData = readData;
  assign mem.done  = (state == busRelease) && !memAck;  // Handshake closed

  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      state  <= busIdle;
      memReq <= 1'b0;
      memWe  <= 1'b0;
    end
    else
    begin
      case (state)
        busIdle:
          if (mem.start)
          begin
            memReq <= 1'b1;
            memWe  <= mem.write;
            state  <= busReq;
          end
        busReq:
          if (memAck)
          begin
            memReq <= 1'b0;
            state  <= busRelease;
          end
        busRelease:
          if (!memAck)
          begin
            memWe <= 1'b0;
            state <= busIdle;
          end
        default: state <= busIdle;
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (state == busIdle && mem.start)
    begin
      memAddr  <= mem.addr;
      memWData <= mem.wData;
    end
    if (state == busReq && memAck)
      readData <= memRData;   // Valid while ack is high
  end
endmodule

// ==== hdl/aluUnit.sv ====
`timescale 1ns/1ps
`include "dzcpu_defines.svh"

module aluUnit
(
  input  dzcpuPkg::aluOpT       op,
  input  logic [`DZ_DATA_W-1:0] a,
  input  logic [`DZ_DATA_W-1:0] b,
  input  logic [`DZ_DATA_W-1:0] flagsIn,
  output logic [`DZ_DATA_W-1:0] result,
  output logic [`DZ_DATA_W-1:0] flagsOut
);
  logic [4:0] halfAdd;
  logic       nf;
  logic       hf;
  logic       cf;

  assign halfAdd = {1'b0, a[3:0]} + {1'b0, b[3:0]};

  always_comb
  begin
    result = a;
    nf     = 1'b0;
    hf     = 1'b0;
    cf     = flagsIn[`DZ_FLAG_C];   // Kept by INC/DEC
    case (op)
      dzcpuPkg::aluAdd:
      begin
        {cf, result} = {1'b0, a} + {1'b0, b};
        hf = halfAdd[4];
      end
      dzcpuPkg::aluSub, dzcpuPkg::aluCp:
      begin
        {cf, result} = {1'b0, a} - {1'b0, b};  // Bit 8 is the borrow
        nf = 1'b1;
        hf = a[3:0] < b[3:0];
      end
      dzcpuPkg::aluAnd:
      begin
        result = a & b;
        hf     = 1'b1;
        cf     = 1'b0;
      end
      dzcpuPkg::aluXor:
      begin
        result = a ^ b;
        cf     = 1'b0;
      end
      dzcpuPkg::aluOr:
      begin
        result = a | b;
        cf     = 1'b0;
      end
      dzcpuPkg::aluInc:
      begin
        result = a + 1'b1;
        hf     = (result[3:0] == 4'h0);
      end
      default:
      begin
        result = a - 1'b1;            // DEC
        nf     = 1'b1;
        hf     = (result[3:0] == 4'hF);
      end
    endcase
  end

  always_comb
  begin
    flagsOut             = '0;
    flagsOut[`DZ_FLAG_Z] = (result == '0);
    flagsOut[`DZ_FLAG_N] = nf;
    flagsOut[`DZ_FLAG_H] = hf;
    flagsOut[`DZ_FLAG_C] = cf;
  end
endmodule

// ==== hdl/memAccessIf.sv ====
`timescale 1ns/1ps
`include "dzcpu_defines.svh"

interface memAccessIf;
  logic                  start;   // One-cycle request pulse
  logic                  write;
  logic [`DZ_ADDR_W-1:0] addr;
  logic [`DZ_DATA_W-1:0] wData;
  logic [`DZ_DATA_W-1:0] rData;   // Held until next start
  logic                  done;

  modport control (output start, output write, input done, input rData);

  modport data (output addr, output wData, input rData);

  modport master (
    input start, input write, input addr, input wData,
    output rData, output done
  );
endinterface

// ==== hdl/dzcpuPkg.sv ====
`include "dzcpu_defines.svh"

package dzcpuPkg;

  // One opcode byte, seen as a load or as an operate instruction
  typedef union packed {
    struct packed {
      logic [1:0] group;
      logic [2:0] dst;
      logic [2:0] src;
    } ld;
    struct packed {
      logic [1:0] group;
      logic [2:0] op;     // ALU op or jump condition
      logic [2:0] src;
    } opr;
  } zInsnT;

  typedef enum logic [2:0] {
    aluAdd, aluSub, aluAnd, aluXor, aluOr, aluCp, aluInc, aluDec
  } aluOpT;

  typedef enum logic [2:0] {
    cmdNone, cmdFetch, cmdRegFromBus, cmdRegFromReg, cmdAlu, cmdTempLo, cmdTempHi, cmdJump
  } uCmdT;

  typedef enum logic [1:0] {memNone, memRead, memWrite} memOpT;

  typedef enum logic {addrPc, addrHl} addrSelT;

  typedef enum logic [1:0] {eofNever, eofAlways, eofIfCondFalse} eofT;

  typedef struct packed {
    uCmdT    cmd;
    memOpT   memOp;
    addrSelT addrSel;
    logic    incPc;
    eofT     eof;
  } uopT;

endpackage

// ==== hdl/dzcpu_defines.svh ====
`ifndef DZCPU_DEFINES_SVH
`define DZCPU_DEFINES_SVH

// Bus widths
`define DZ_DATA_W 8
`define DZ_ADDR_W 16

// Reset values
`define DZ_RESET_PC   16'h0000
`define DZ_FLAGS_INIT 8'hB0

// Flag bit positions, low nibble stays zero
`define DZ_FLAG_Z 7
`define DZ_FLAG_N 6
`define DZ_FLAG_H 5
`define DZ_FLAG_C 4

// Microcode store
`define DZ_UPC_W      4
`define DZ_UROM_DEPTH 10

`endif
